//--- verilog/jumpPkg.sv
// Branch decode shared types
package jumpPkg;

  localparam int instrWidth = 80;
  localparam int ipWidth = 48;
  localparam int stackDepth = 8;
  localparam int laneCount = 2;

  // Stack pointer width.
  localparam int ptrWidth = $clog2(stackDepth);

  typedef enum logic [2:0] {
    notJump,
    condJump,
    uncondJump,
    indirJump,
    callJump,
    retJump
  } jumpKindE;

  // One lane of the fetch bundle.
  typedef struct packed {
    logic                  valid;
    logic [instrWidth-1:0] instr;
    logic [3:0]            magic;
    logic [ipWidth-1:0]    pc;
  } fetchSlotS;

  typedef struct packed {
    jumpKindE           kind;
    logic [3:0]         cond;
    logic [ipWidth-1:0] offset;
    logic [3:0]         length;
  } jumpInfoS;

  typedef struct packed {
    logic               valid;
    jumpKindE           kind;
    logic [3:0]         cond;
    logic [ipWidth-1:0] target;
    logic               stackMiss;
  } redirectS;

  // Request toward the return stack.
  typedef struct packed {
    logic               push;
    logic               pop;
    logic [ipWidth-1:0] addr;
  } stackReqS;

endpackage

//--- verilog/jumpDecoder.sv
// Jump instruction decoder
`timescale 1ns/1ns

module jumpDecoder import jumpPkg::*; (
  input  fetchSlotS slot,
  output jumpInfoS  info
);

  logic [7:0] opcode;
  logic [2:0] subOp;
  logic [3:0] magic;
  logic [instrWidth-1:0] instr;

  logic isShort;
  logic isBasicCond;
  logic isLongCond;
  logic isUncond;
  logic isIndir;
  logic isCall;
  logic isRet;

  // Common wide offset field.
  logic [ipWidth-1:0] wideOffset;

  assign instr = slot.instr;
  assign magic = slot.magic;
  assign opcode = instr[7:0];
  assign subOp = instr[15:13];

  assign isShort = (opcode[5:2] == 4'b1100) & ~magic[0];
  assign isBasicCond = (opcode[7:4] == 4'b1010) & magic[0];
  assign isLongCond = (opcode == 8'd180) & magic[0];
  assign isUncond = (opcode == 8'd181) & magic[0];
  assign isIndir = (opcode == 8'd182) & (subOp == 3'd0) & magic[0];
  assign isCall = (opcode == 8'd182) & ((subOp == 3'd1) | (subOp == 3'd2)) & magic[0];
  assign isRet = (opcode == 8'd182) & (subOp == 3'd3) & magic[0];

  assign wideOffset = {{16{instr[47]}}, instr[47:17], 1'b0};

  // Byte length from the magic tag.
  always_comb begin
    if (!magic[0]) begin
      info.length = 4'd2;
    end else if (magic[1:0] == 2'b01) begin
      info.length = 4'd4;
    end else if (magic[2:0] == 3'b011) begin
      info.length = 4'd6;
    end else begin
      info.length = 4'd8;
    end
  end

  always_comb begin
    info.kind = notJump;
    info.cond = 4'd0;
    info.offset = '0;
    if (isShort) begin
      info.cond = {instr[7:6], instr[1:0]};
      info.offset = {{39{instr[15]}}, instr[15:8], 1'b0};
      // Never-taken encoding reused as always taken.
      if ({instr[7:6], instr[1:0]} == 4'hf) begin
        info.kind = uncondJump;
        info.cond = 4'd0;
      end else begin
        info.kind = condJump;
      end
    end else if (isBasicCond) begin
      info.kind = condJump;
      info.cond = {(magic[1:0] == 2'b01) ? instr[18] : instr[32], opcode[3:1]};
      if (magic[1:0] == 2'b01) begin
        info.offset = {{34{instr[31]}}, instr[31:19], 1'b0};
      end else if (magic[2:0] == 3'b011) begin
        info.offset = {{32{instr[47]}}, instr[47:33], 1'b0};
      end else if (magic[2:0] == 3'b111) begin
        info.offset = {{16{instr[63]}}, instr[63:33], 1'b0};
      end
    end else if (isLongCond) begin
      info.kind = condJump;
      info.cond = instr[11:8];
      if (magic[1:0] == 2'b01) begin
        info.offset = {{27{instr[31]}}, instr[31:12], 1'b0};
      end else begin
        info.offset = wideOffset;
      end
    end else if (isUncond) begin
      info.kind = uncondJump;
      if (magic[1:0] == 2'b01) begin
        info.offset = {{23{instr[31]}}, instr[31:8], 1'b0};
      end else begin
        info.offset = wideOffset;
      end
    end else if (isIndir) begin
      // Target comes from a register, offset stays zero.
      info.kind = indirJump;
    end else if (isCall) begin
      info.kind = callJump;
      if (magic[1:0] == 2'b01) begin
        info.offset = {{31{instr[31]}}, instr[31:16], 1'b0};
      end else begin
        info.offset = wideOffset;
      end
    end else if (isRet) begin
      info.kind = retJump;
    end
  end

endmodule

//--- verilog/branchLane.sv
// Branch lane register stage
`timescale 1ns/1ns

module branchLane import jumpPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  fetchSlotS          slot,
  input  logic               stall,
  input  logic               grant,
  input  logic [ipWidth-1:0] popAddr,
  input  logic               popEmpty,
  output stackReqS           req,
  output redirectS           redirect
);

  jumpInfoS decInfo;
  jumpInfoS infoQ;
  logic [ipWidth-1:0] pcQ;
  logic pendQ;

  logic accept;
  logic usesStack;
  logic done;

  jumpDecoder decoder_inst (
    .slot (slot),
    .info (decInfo)
  );

  assign accept = slot.valid & ~stall;
  assign usesStack = (infoQ.kind == callJump) | (infoQ.kind == retJump);
  assign done = pendQ & (~usesStack | grant);

  // Stack request stays up until granted.
  assign req.push = pendQ & (infoQ.kind == callJump);
  assign req.pop = pendQ & (infoQ.kind == retJump);
  assign req.addr = pcQ + ipWidth'(infoQ.length);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pendQ <= 1'b0;
    end else if (accept) begin
      pendQ <= (decInfo.kind != notJump);
    end else if (done) begin
      pendQ <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      infoQ <= decInfo;
      pcQ <= slot.pc;
    end
  end

  always_comb begin
    redirect.valid = done;
    redirect.kind = infoQ.kind;
    redirect.cond = infoQ.cond;
    redirect.target = pcQ + infoQ.offset;
    redirect.stackMiss = 1'b0;
    if (infoQ.kind == retJump) begin
      // Empty stack gives a zero target.
      redirect.target = popEmpty ? '0 : popAddr;
      redirect.stackMiss = popEmpty;
    end
  end

  // A waiting item is not overwritten before its grant.
  waitKeepsItem: assert property (@(posedge clk) disable iff (!rstN)
    (pendQ && usesStack && !grant) |=> (pendQ && usesStack));

endmodule

//--- verilog/stackArbiter.sv
// Return stack arbiter
`timescale 1ns/1ns

module stackArbiter import jumpPkg::*; (
  input  stackReqS           req0,
  input  stackReqS           req1,
  input  logic [ipWidth-1:0] top,
  input  logic               empty,
  output logic               grant0,
  output logic               grant1,
  output stackReqS           stackReq,
  output logic [ipWidth-1:0] popAddr,
  output logic               popEmpty,
  output logic               wait1
);

  logic want1;

  // Lane 0 holds the older instruction and always wins.
  assign grant0 = req0.push | req0.pop;
  assign want1 = req1.push | req1.pop;
  assign grant1 = want1 & ~grant0;
  assign wait1 = want1 & grant0;

  always_comb begin
    if (grant0) begin
      stackReq = req0;
    end else if (grant1) begin
      stackReq = req1;
    end else begin
      stackReq = '0;
    end
  end

  // Top entry read at grant time.
  assign popAddr = top;
  assign popEmpty = empty;

endmodule

//--- verilog/returnStack.sv
// Circular return address stack
`timescale 1ns/1ns

module returnStack import jumpPkg::*; (
  input  logic               clk,
  input  logic               rstN,
  input  stackReqS           req,
  output logic [ipWidth-1:0] top,
  output logic               empty
);

  logic [ipWidth-1:0] mem [stackDepth];
  // Pointer to the next free entry.
  logic [ptrWidth-1:0] ptrQ;
  logic [ptrWidth:0] countQ;
  logic [ptrWidth-1:0] topIdx;
  logic full;

  assign topIdx = ptrQ - ptrWidth'(1);
  assign top = mem[topIdx];
  assign empty = (countQ == '0);
  assign full = (countQ == (ptrWidth + 1)'(stackDepth));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ptrQ <= '0;
      countQ <= '0;
    end else if (req.push) begin
      // Full stack wraps over the oldest entry.
      ptrQ <= ptrQ + ptrWidth'(1);
      if (!full) begin
        countQ <= countQ + 1'b1;
      end
    end else if (req.pop && !empty) begin
      ptrQ <= topIdx;
      countQ <= countQ - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req.push) begin
      mem[ptrQ] <= req.addr;
    end
  end

  // A pushed address becomes the new top entry.
  pushedOnTop: assert property (@(posedge clk) disable iff (!rstN)
    req.push |=> (top == $past(req.addr)));

endmodule

//--- verilog/branchUnit.sv
// Branch unit top level
`timescale 1ns/1ns

module branchUnit import jumpPkg::*; (
  input  logic                            clk,
  input  logic                            rstN,
  input  fetchSlotS [laneCount-1:0]       slotIn,
  output redirectS  [laneCount-1:0]       redirectOut,
  output logic                            hold
);

  stackReqS [laneCount-1:0] laneReq;
  logic [laneCount-1:0] laneGrant;
  stackReqS stackReq;
  logic [ipWidth-1:0] stackTop;
  logic stackEmpty;
  logic [ipWidth-1:0] popAddr;
  logic popEmpty;

  for (genvar i = 0; i < laneCount; i++) begin : gLane
    branchLane branchLane_inst (
      .clk      (clk),
      .rstN     (rstN),
      .slot     (slotIn[i]),
      .stall    (hold),
      .grant    (laneGrant[i]),
      .popAddr  (popAddr),
      .popEmpty (popEmpty),
      .req      (laneReq[i]),
      .redirect (redirectOut[i])
    );
  end

  // Lane 1 stalls the whole bundle while it waits.
  stackArbiter stackArbiter_inst (
    .req0     (laneReq[0]),
    .req1     (laneReq[1]),
    .top      (stackTop),
    .empty    (stackEmpty),
    .grant0   (laneGrant[0]),
    .grant1   (laneGrant[1]),
    .stackReq (stackReq),
    .popAddr  (popAddr),
    .popEmpty (popEmpty),
    .wait1    (hold)
  );

  returnStack returnStack_inst (
    .clk   (clk),
    .rstN  (rstN),
    .req   (stackReq),
    .top   (stackTop),
    .empty (stackEmpty)
  );

endmodule

//--- dv/jumpModel.svh
// Jump reference model
`ifndef JUMP_MODEL_SVH
`define JUMP_MODEL_SVH

typedef enum int {
  formShort, formBasic, formLong, formUncond, formIndir, formCall, formRet, formNone
} formE;

// Shadow copy of the return stack, newest entry at the back.
logic [ipWidth-1:0] shadowStack[$];

function automatic logic [ipWidth-1:0] sextDouble(input logic [31:0] disp, input int w);
  logic [ipWidth-1:0] mask;
  mask = (ipWidth'(1) << w) - ipWidth'(1);
  return ((ipWidth'(disp) & mask) | (disp[w-1] ? ~mask : '0)) << 1;
endfunction

// Places one jump form into a random window and gives its expected decode.
function automatic void encodeJump(input formE form, input logic [3:0] cond, input int variant,
    input logic [instrWidth-1:0] fill, output logic [instrWidth-1:0] instr,
    output logic [3:0] magic, output jumpInfoS info);
  int lsb;
  int w;
  instr = fill;
  lsb = 17;
  w = (variant == 0) ? 0 : 31;
  magic = (variant == 0) ? {fill[3:2], 2'b01} : {fill[3], (variant == 1) ? 3'b011 : 3'b111};
  info.kind = notJump;
  info.cond = 4'd0;
  info.length = 4'd4 + 4'(2 * variant);
  case (form)
    formShort: begin
      magic = {fill[3:1], 1'b0};
      info.length = 4'd2;
      instr[7:0] = {cond[3:2], 4'b1100, cond[1:0]};
      {lsb, w} = {32'd8, 32'd8};
      // All ones condition means always taken.
      info.kind = (cond == 4'hf) ? uncondJump : condJump;
      info.cond = (cond == 4'hf) ? 4'd0 : cond;
    end
    formBasic: begin
      instr[7:0] = {4'b1010, cond[2:0], fill[8]};
      info.kind = condJump;
      info.cond = cond;
      if (variant == 0) begin
        instr[18] = cond[3];
        {lsb, w} = {32'd19, 32'd13};
      end else begin
        instr[32] = cond[3];
        {lsb, w} = {32'd33, (variant == 1) ? 32'd15 : 32'd31};
      end
    end
    formLong: begin
      instr[11:0] = {cond, 8'd180};
      info.kind = condJump;
      info.cond = cond;
      if (variant == 0) {lsb, w} = {32'd12, 32'd20};
    end
    formUncond: begin
      instr[7:0] = 8'd181;
      info.kind = uncondJump;
      if (variant == 0) {lsb, w} = {32'd8, 32'd24};
    end
    formCall: begin
      instr[15:13] = fill[9] ? 3'd2 : 3'd1;
      instr[7:0] = 8'd182;
      info.kind = callJump;
      if (variant == 0) {lsb, w} = {32'd16, 32'd16};
    end
    formIndir, formRet: begin
      instr[15:13] = (form == formRet) ? 3'd3 : 3'd0;
      instr[7:0] = 8'd182;
      info.kind = (form == formRet) ? retJump : indirJump;
      w = 0;
    end
    default: begin
      instr[7:0] = 8'h90;
      w = 0;
    end
  endcase
  info.offset = (w == 0) ? '0 : sextDouble(32'(instr >> lsb), w);
endfunction

// Expected redirect, with the shadow stack updated in program order.
function automatic redirectS predictRedirect(input jumpInfoS info, input logic [ipWidth-1:0] pc);
  redirectS rd;
  rd.valid = 1'b1;
  rd.kind = info.kind;
  rd.cond = info.cond;
  rd.target = pc + info.offset;
  rd.stackMiss = 1'b0;
  if (info.kind == callJump) begin
    shadowStack.push_back(pc + ipWidth'(info.length));
    // Oldest entry is lost when full.
    if (shadowStack.size() > stackDepth) shadowStack.pop_front();
  end else if (info.kind == retJump) begin
    rd.stackMiss = (shadowStack.size() == 0);
    rd.target = '0;
    if (!rd.stackMiss) rd.target = shadowStack.pop_back();
  end
  return rd;
endfunction

`endif

//--- dv/branchUnitTb.sv
// Branch unit testbench
`timescale 1ns/1ns

module branchUnitTb import jumpPkg::*; ();

  localparam int clkPeriod = 4;
  localparam int randomCount = 60;
  localparam int nonJumpCount = 20;
  // Bundles of all tests plus drain time per test.
  localparam int bundleCount = randomCount + nonJumpCount + 40;
  localparam int stimCycles = 10 + bundleCount + 6 * 26;

  typedef struct packed {
    redirectS    rd;
    logic [31:0] atEdge;
  } expectS;

  logic clk;
  logic rstN;
  fetchSlotS [laneCount-1:0] slotIn;
  redirectS [laneCount-1:0] redirectOut;
  logic hold;

  expectS expQ0[$];
  expectS expQ1[$];
  int edgeCount;
  int testErrors;
  int testsPassed;
  int testsFailed;
  string testName;
  logic [31:0] lcgState;

  `include "jumpModel.svh"

  branchUnit branchUnit_inst (
    .clk         (clk),
    .rstN        (rstN),
    .slotIn      (slotIn),
    .redirectOut (redirectOut),
    .hold        (hold)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState ^ (lcgState >> 15);
  endfunction

  function automatic void buildSlot(input formE form, input logic [3:0] cond,
      output fetchSlotS slot, output jumpInfoS info);
    logic [instrWidth-1:0] instr;
    logic [3:0] magic;
    encodeJump(form, cond, int'(lcgNext() % 3), instrWidth'({lcgNext(), lcgNext(), lcgNext()}),
      instr, magic, info);
    slot = {1'b1, instr, magic, ipWidth'({lcgNext(), lcgNext()})};
  endfunction

  task automatic applyReset();
    rstN = 1'b0;
    slotIn = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    shadowStack.delete();
    expQ0.delete();
    expQ1.delete();
  endtask

  // Drives one bundle at a falling edge and queues what each lane should report.
  task automatic presentBundle(input fetchSlotS s0, input jumpInfoS i0,
      input fetchSlotS s1, input jumpInfoS i1);
    expectS e;
    logic stack0;
    while (hold) @(negedge clk);
    slotIn[0] = s0;
    slotIn[1] = s1;
    stack0 = s0.valid && (i0.kind == callJump || i0.kind == retJump);
    if (s0.valid && i0.kind != notJump) begin
      e = {predictRedirect(i0, s0.pc), 32'(edgeCount + 2)};
      expQ0.push_back(e);
    end
    if (s1.valid && i1.kind != notJump) begin
      // Lane 1 waits a cycle when both lanes want the stack.
      e.rd = predictRedirect(i1, s1.pc);
      e.atEdge = 32'(edgeCount + ((stack0 && (i1.kind == callJump || i1.kind == retJump)) ? 3 : 2));
      expQ1.push_back(e);
    end
    @(negedge clk);
    slotIn[0].valid = 1'b0;
    slotIn[1].valid = 1'b0;
  endtask

  task automatic presentOne(input int lane, input formE form);
    fetchSlotS s;
    fetchSlotS idle;
    jumpInfoS info;
    buildSlot(form, 4'd0, s, info);
    idle = '0;
    if (lane == 0) presentBundle(s, info, idle, info);
    else presentBundle(idle, info, s, info);
  endtask

  task automatic startTest(input string name);
    testName = name;
    testErrors = 0;
  endtask

  task automatic finishTest();
    int waitCycles;
    waitCycles = 0;
    while ((expQ0.size() != 0 || expQ1.size() != 0) && waitCycles < 20) begin
      @(negedge clk);
      waitCycles++;
    end
    repeat (3) @(negedge clk);
    assert (expQ0.size() == 0 && expQ1.size() == 0) else begin
      $display("%s: some expected redirects never arrived", testName);
      testErrors++;
    end
    if (testErrors == 0) begin
      testsPassed++;
      $display("%s: passed", testName);
    end else begin
      testsFailed++;
      $display("%s: failed with %0d errors", testName, testErrors);
    end
  endtask

  task automatic checkLane(input int lane);
    expectS e;
    redirectS got;
    got = redirectOut[lane];
    e = '0;
    if (got.valid) begin
      if (lane == 0 && expQ0.size() != 0) e = expQ0.pop_front();
      if (lane == 1 && expQ1.size() != 0) e = expQ1.pop_front();
      assert (e.rd.valid) else begin
        $display("%s: lane %0d gave a redirect that was not expected", testName, lane);
        testErrors++;
      end
      if (e.rd.valid) begin
        assert (got == e.rd) else begin
          $display("CHECK FAILED %s lane %0d: expected %h, actual %h", testName, lane, e.rd, got);
          testErrors++;
        end
        assert (edgeCount == int'(e.atEdge)) else begin
          $display("CHECK FAILED %s lane %0d cycle: expected %0d, actual %0d",
            testName, lane, e.atEdge, edgeCount);
          testErrors++;
        end
      end
    end
  endtask

  // Redirects only change after a rising edge, so they are compared at the next one.
  initial begin : compareProc
    edgeCount = 0;
    forever begin
      @(posedge clk);
      edgeCount++;
      if (rstN) begin
        checkLane(0);
        checkLane(1);
      end
    end
  end

  initial begin : watchdog
    #((stimCycles * 2 + 100) * clkPeriod);
    $display("Timeout: the tests did not finish within %0d ns", (stimCycles * 2 + 100) * clkPeriod);
    $display("Some tests failed");
    $finish;
  end

  initial begin : mainProc
    fetchSlotS s0;
    fetchSlotS s1;
    jumpInfoS i0;
    jumpInfoS i1;
    lcgState = 32'd62174;
    testsPassed = 0;
    testsFailed = 0;
    applyReset();

    startTest("decodeTarget");
    for (int n = 0; n < randomCount; n++) begin
      buildSlot(formE'(lcgNext() % 4), 4'(lcgNext() >> 20), s0, i0);
      buildSlot(formE'(lcgNext() % 4), 4'(lcgNext() >> 20), s1, i1);
      presentBundle(s0, i0, s1, i1);
    end
    buildSlot(formShort, 4'hf, s0, i0);
    s1.valid = 1'b0;
    presentBundle(s0, i0, s1, i1);
    finishTest();

    startTest("nonJumpIndirect");
    for (int n = 0; n < nonJumpCount; n++) begin
      buildSlot(lcgNext() % 2 ? formNone : formIndir, 4'd0, s0, i0);
      buildSlot(lcgNext() % 2 ? formNone : formIndir, 4'd0, s1, i1);
      presentBundle(s0, i0, s1, i1);
    end
    finishTest();

    startTest("callReturn");
    presentOne(0, formCall);
    presentOne(1, formRet);
    presentOne(1, formCall);
    presentOne(0, formCall);
    presentOne(1, formRet);
    presentOne(0, formRet);
    finishTest();

    startTest("sameBundleConflict");
    buildSlot(formCall, 4'd0, s0, i0);
    buildSlot(formRet, 4'd0, s1, i1);
    presentBundle(s0, i0, s1, i1);
    assert (hold === 1'b1) else begin
      $display("CHECK FAILED %s hold: expected 1, actual %b", testName, hold);
      testErrors++;
    end
    @(negedge clk);
    assert (hold === 1'b0) else begin
      $display("CHECK FAILED %s hold release: expected 0, actual %b", testName, hold);
      testErrors++;
    end
    finishTest();

    startTest("stackLimits");
    presentOne(0, formRet);
    for (int n = 0; n < 9; n++) presentOne(n % 2, formCall);
    for (int n = 0; n < 9; n++) presentOne(n % 2, formRet);
    finishTest();

    startTest("resetClearsStack");
    presentOne(0, formCall);
    repeat (3) @(negedge clk);
    applyReset();
    presentOne(1, formRet);
    finishTest();

    $display("Tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
    if (testsFailed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+dv
verilog/jumpPkg.sv
verilog/jumpDecoder.sv
verilog/branchLane.sv
verilog/stackArbiter.sv
verilog/returnStack.sv
verilog/branchUnit.sv
dv/branchUnitTb.sv

//--- Bender.yml
package:
  name: branch_unit

sources:
  - verilog/jumpPkg.sv
  - verilog/jumpDecoder.sv
  - verilog/branchLane.sv
  - verilog/stackArbiter.sv
  - verilog/returnStack.sv
  - verilog/branchUnit.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/branchUnitTb.sv
